//--- hdl/a2_glue_macros.svh
`ifndef A2_GLUE_MACROS_SVH
`define A2_GLUE_MACROS_SVH

// Apple II bus data width
`define A2_DATA_W 8

// Emulated cards answering on the bus
`define NUM_CARDS 3

// Audio widths
`define AUDIO_SRC_W 10
`define AUDIO_OUT_W 16

// Depth of the bus clock synchronizer
`define SYNC_STAGES 2

// Clocks the button must hold still before the level is accepted
`define DEBOUNCE_CYCLES 10000

// Bus drive permissions
`define BUS_DATA_OUT_ENABLE 1
`define IRQ_OUT_ENABLE 1

`endif

//--- hdl/a2_bus_pkg.sv
`include "a2_glue_macros.svh"

package a2_bus_pkg;

    // Bus clocks recovered into the logic domain
    typedef struct packed {
        logic phi0;
        logic phi1;
        logic phi1_posedge;
        logic phi1_negedge;
        logic clk_2m_posedge;
        logic clk_7m;
        logic clk_7m_posedge;
        logic clk_7m_negedge;
        logic clk_14m_posedge;
    } a2_clk_t;

    // One card's reply to a bus cycle
    typedef struct packed {
        logic                  rd_en;
        logic [`A2_DATA_W-1:0] data;
        logic                  irq_n;
    } card_resp_t;

    // Index 0 serial, 1 sprite, 2 sound; lower index wins
    typedef card_resp_t [`NUM_CARDS-1:0] card_resp_vec_t;

    // What goes back onto the data bus
    typedef struct packed {
        logic                  data_out_en;
        logic [`A2_DATA_W-1:0] data_out;
    } bus_drive_t;

endpackage

//--- hdl/a2_audio_pkg.sv
`include "a2_glue_macros.svh"

package a2_audio_pkg;

    // Raw audio inputs, all unsigned
    typedef struct packed {
        logic                    speaker;
        logic [`AUDIO_SRC_W-1:0] ssp;
        logic [`AUDIO_SRC_W-1:0] mb_l;
        logic [`AUDIO_SRC_W-1:0] mb_r;
    } audio_src_t;

    // Mixed stereo sample
    typedef struct packed {
        logic [`AUDIO_OUT_W-1:0] left;
        logic [`AUDIO_OUT_W-1:0] right;
    } audio_sample_t;

    // Four-phase handoff to the sink
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_REQ,
        HS_DROP
    } audio_hs_state_e;

endpackage

//--- hdl/phase_sync.sv
`include "a2_glue_macros.svh"

module phase_sync (
    input  logic clk_logic_w,
    input  logic reset_i,
    input  logic level_i,
    output logic level_o,
    output logic level_n_o,
    output logic posedge_o,
    output logic negedge_o
);

    logic [`SYNC_STAGES-1:0] sync_r;
    logic                    filt_r;
    logic                    filt_prev_r;
    logic                    samples_agree;

    // Shift in the asynchronous bus clock
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            sync_r <= '0;
        end else begin
            sync_r <= {sync_r[`SYNC_STAGES-2:0], level_i};
        end
    end

    // A single-cycle glitch never shows up in both of the top two stages
    assign samples_agree = (sync_r[`SYNC_STAGES-1] == sync_r[`SYNC_STAGES-2]);

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            filt_r      <= 1'b0;
            filt_prev_r <= 1'b0;
        end else begin
            if (samples_agree) begin
                filt_r <= sync_r[`SYNC_STAGES-1];
            end
            filt_prev_r <= filt_r;
        end
    end

    assign level_o   = filt_r;
    assign level_n_o = ~filt_r;

    // Strobes line up with the cycle the filtered level changes
    assign posedge_o = filt_r & ~filt_prev_r;
    assign negedge_o = ~filt_r & filt_prev_r;

    // Two agreeing samples are needed, so edges never land on back-to-back cycles
    a_edges_spaced: assert property (
        @(posedge clk_logic_w) disable iff (reset_i)
        (posedge_o || negedge_o) |=> !(posedge_o || negedge_o)
    );

endmodule

//--- hdl/card_bus_arbiter.sv
`include "a2_glue_macros.svh"

module card_bus_arbiter
    import a2_bus_pkg::*;
(
    input  logic                  clk_logic_w,
    input  logic                  reset_i,
    input  card_resp_vec_t        resp_i,
    input  logic [`A2_DATA_W-1:0] bus_data_i,
    output bus_drive_t            drive_o,
    output logic                  irq_n_o
);

    logic                  any_rd;
    logic                  irq_all_n;
    logic [`A2_DATA_W-1:0] sel_data;

    logic                  data_out_en_r;
    logic [`A2_DATA_W-1:0] data_out_r;
    logic                  irq_n_r;

    // Walk from the lowest priority up so the serial card overrides the rest
    always_comb begin
        sel_data  = bus_data_i;
        any_rd    = 1'b0;
        irq_all_n = 1'b1;
        for (int i = `NUM_CARDS - 1; i >= 0; i--) begin
            if (resp_i[i].rd_en) begin
                sel_data = resp_i[i].data;
            end
            any_rd    = any_rd | resp_i[i].rd_en;
            // Wired-AND of the open-drain interrupt lines
            irq_all_n = irq_all_n & resp_i[i].irq_n;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            data_out_en_r <= 1'b0;
            irq_n_r       <= 1'b1;
        end else begin
            data_out_en_r <= any_rd && (`BUS_DATA_OUT_ENABLE != 0);
            irq_n_r       <= (`IRQ_OUT_ENABLE != 0) ? irq_all_n : 1'b1;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        data_out_r <= sel_data;
    end

    assign drive_o = '{data_out_en: data_out_en_r, data_out: data_out_r};
    assign irq_n_o = irq_n_r;

    // The serial card always wins when it reads
    a_serial_wins: assert property (
        @(posedge clk_logic_w) disable iff (reset_i)
        $past(resp_i[0].rd_en) |-> drive_o.data_out == $past(resp_i[0].data)
    );

endmodule

//--- hdl/audio_mixer.sv
`include "a2_glue_macros.svh"

module audio_mixer
    import a2_audio_pkg::*;
(
    input  logic          clk_logic_w,
    input  logic          reset_i,
    input  audio_src_t    src_i,
    output audio_sample_t sample_o,
    output logic          sample_req_o,
    input  logic          sample_ack_i
);

    // Zero bits above a card source once it has been moved up by 3
    localparam int PAD_W = `AUDIO_OUT_W - `AUDIO_SRC_W - 3;

    logic [`AUDIO_OUT_W-1:0] speaker_ext;
    logic [`AUDIO_OUT_W-1:0] ssp_ext;
    logic [`AUDIO_OUT_W-1:0] mb_l_ext;
    logic [`AUDIO_OUT_W-1:0] mb_r_ext;
    audio_sample_t           mix;

    audio_hs_state_e         state_r;
    audio_sample_t           sample_r;

    // Cards go up by 3, the speaker sits at bit 12
    assign speaker_ext = {{(`AUDIO_OUT_W - 13){1'b0}}, src_i.speaker, 12'b0};
    assign ssp_ext     = {{PAD_W{1'b0}}, src_i.ssp, 3'b000};
    assign mb_l_ext    = {{PAD_W{1'b0}}, src_i.mb_l, 3'b000};
    assign mb_r_ext    = {{PAD_W{1'b0}}, src_i.mb_r, 3'b000};

    // Worst case sum stays well below 16 bits
    assign mix.left  = ssp_ext + mb_l_ext + speaker_ext;
    assign mix.right = ssp_ext + mb_r_ext + speaker_ext;

    // Handoff FSM
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            state_r <= HS_IDLE;
        end else begin
            case (state_r)
                HS_IDLE: begin
                    // Wait out a sink that still holds ack from last time
                    if (!sample_ack_i) begin
                        state_r <= HS_REQ;
                    end
                end
                HS_REQ: begin
                    if (sample_ack_i) begin
                        state_r <= HS_DROP;
                    end
                end
                HS_DROP: begin
                    if (!sample_ack_i) begin
                        state_r <= HS_IDLE;
                    end
                end
                default: begin
                    state_r <= HS_IDLE;
                end
            endcase
        end
    end

    // Capture on the same edge that raises req
    always_ff @(posedge clk_logic_w) begin
        if (state_r == HS_IDLE && !sample_ack_i) begin
            sample_r <= mix;
        end
    end

    assign sample_o     = sample_r;
    assign sample_req_o = (state_r == HS_REQ);

    a_sample_stable: assert property (
        @(posedge clk_logic_w) disable iff (reset_i)
        sample_req_o && $past(sample_req_o) |-> sample_o == $past(sample_o)
    );

    a_no_req_under_ack: assert property (
        @(posedge clk_logic_w) disable iff (reset_i)
        $rose(sample_req_o) |-> !$past(sample_ack_i)
    );

endmodule

//--- hdl/overlay_button.sv
`include "a2_glue_macros.svh"

module overlay_button (
    input  logic clk_logic_w,
    input  logic reset_i,
    input  logic button_i,
    output logic overlay_en_o
);

    localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

    logic             button_sync_r;
    logic [CNT_W-1:0] stable_cnt_r;
    logic             debounced_r;
    logic             debounced_prev_r;
    logic             overlay_en_r;
    logic             press;

    // Single flop is enough for a slow mechanical input
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            button_sync_r <= 1'b0;
        end else begin
            button_sync_r <= button_i;
        end
    end

    // Count how long the raw level has differed from the accepted one
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            stable_cnt_r <= '0;
            debounced_r  <= 1'b0;
        end else if (button_sync_r == debounced_r) begin
            stable_cnt_r <= '0;
        end else if (stable_cnt_r == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
            stable_cnt_r <= '0;
            debounced_r  <= button_sync_r;
        end else begin
            stable_cnt_r <= stable_cnt_r + 1'b1;
        end
    end

    assign press = debounced_r & ~debounced_prev_r;

    // Each press flips the overlay
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            debounced_prev_r <= 1'b0;
            overlay_en_r     <= 1'b0;
        end else begin
            debounced_prev_r <= debounced_r;
            if (press) begin
                overlay_en_r <= ~overlay_en_r;
            end
        end
    end

    assign overlay_en_o = overlay_en_r;

endmodule

//--- hdl/a2_card_glue_top.sv
`include "a2_glue_macros.svh"

module a2_card_glue_top
    import a2_bus_pkg::*;
    import a2_audio_pkg::*;
(
    input  logic                  clk_logic_w,
    input  logic                  reset_i,
    input  logic                  a2_phi1_i,
    input  logic                  a2_7m_i,
    output a2_clk_t               a2_clk_o,
    input  card_resp_vec_t        resp_i,
    input  logic [`A2_DATA_W-1:0] bus_data_i,
    output bus_drive_t            drive_o,
    output logic                  irq_n_o,
    input  audio_src_t            src_i,
    output audio_sample_t         sample_o,
    output logic                  sample_req_o,
    input  logic                  sample_ack_i,
    input  logic                  button_i,
    output logic                  overlay_en_o
);

    logic phi1_w;
    logic phi0_w;
    logic phi1_pos_w;
    logic phi1_neg_w;
    logic clk_7m_w;
    logic clk_7m_pos_w;
    logic clk_7m_neg_w;

    // Phi1 from the bus, Phi0 comes out as its inverse
    phase_sync phi1_sync (
        .clk_logic_w (clk_logic_w),
        .reset_i     (reset_i),
        .level_i     (a2_phi1_i),
        .level_o     (phi1_w),
        .level_n_o   (phi0_w),
        .posedge_o   (phi1_pos_w),
        .negedge_o   (phi1_neg_w)
    );

    phase_sync clk_7m_sync (
        .clk_logic_w (clk_logic_w),
        .reset_i     (reset_i),
        .level_i     (a2_7m_i),
        .level_o     (clk_7m_w),
        .level_n_o   (),
        .posedge_o   (clk_7m_pos_w),
        .negedge_o   (clk_7m_neg_w)
    );

    // Both edges of a clock make a strobe at twice its rate
    assign a2_clk_o = '{
        phi0:            phi0_w,
        phi1:            phi1_w,
        phi1_posedge:    phi1_pos_w,
        phi1_negedge:    phi1_neg_w,
        clk_2m_posedge:  phi1_pos_w | phi1_neg_w,
        clk_7m:          clk_7m_w,
        clk_7m_posedge:  clk_7m_pos_w,
        clk_7m_negedge:  clk_7m_neg_w,
        clk_14m_posedge: clk_7m_pos_w | clk_7m_neg_w
    };

    card_bus_arbiter u_arbiter (
        .clk_logic_w (clk_logic_w),
        .reset_i     (reset_i),
        .resp_i      (resp_i),
        .bus_data_i  (bus_data_i),
        .drive_o     (drive_o),
        .irq_n_o     (irq_n_o)
    );

    audio_mixer u_mixer (
        .clk_logic_w  (clk_logic_w),
        .reset_i      (reset_i),
        .src_i        (src_i),
        .sample_o     (sample_o),
        .sample_req_o (sample_req_o),
        .sample_ack_i (sample_ack_i)
    );

    overlay_button u_button (
        .clk_logic_w  (clk_logic_w),
        .reset_i      (reset_i),
        .button_i     (button_i),
        .overlay_en_o (overlay_en_o)
    );

endmodule

//--- dv/a2_card_glue_tb.sv
`include "a2_glue_macros.svh"

module a2_card_glue_tb
    import a2_bus_pkg::*;
    import a2_audio_pkg::*;
();

    localparam int ARB_N       = 8;
    localparam int AUDIO_N     = 7;
    localparam int BP_ROUNDS   = 5;
    localparam int PHASE_PAIRS = 20;
    localparam int PRESSES     = 3;
    localparam int REQ_WAIT    = 20;
    // Worst case cycles per test part, doubled for the watchdog
    localparam int WORST_CYCLES = 12 + ARB_N * 2 + AUDIO_N * (2 * REQ_WAIT + 10)
        + (BP_ROUNDS + 1) * (2 * REQ_WAIT + 30) + 2 * (2 * PHASE_PAIRS * 9 + 8)
        + PRESSES * (150 + 2 * (`DEBOUNCE_CYCLES + 4));
    localparam int WATCHDOG_TIME = 2 * WORST_CYCLES * 8;

    typedef struct packed {
        card_resp_vec_t        resp;
        logic [`A2_DATA_W-1:0] bus;
        bus_drive_t            exp_drive;
        logic                  exp_irq_n;
    } arb_vec_t;

    typedef struct packed {
        audio_src_t    src;
        audio_sample_t exp;
    } audio_vec_t;

    logic                  clk_logic_w = 1'b0;
    logic                  reset_i;
    logic                  a2_phi1_i;
    logic                  a2_7m_i;
    a2_clk_t               a2_clk_o;
    card_resp_vec_t        resp_i;
    logic [`A2_DATA_W-1:0] bus_data_i;
    bus_drive_t            drive_o;
    logic                  irq_n_o;
    audio_src_t            src_i;
    audio_sample_t         sample_o;
    logic                  sample_req_o;
    logic                  sample_ack_i;
    logic                  button_i;
    logic                  overlay_en_o;

    arb_vec_t   arb_tab [ARB_N];
    audio_vec_t audio_tab [AUDIO_N];
    int         errors = 0;
    int         strobe_cnt [6] = '{0, 0, 0, 0, 0, 0};
    logic [5:0] strobe_w;
    logic       exp_overlay;
    logic [31:0] rnd;

    a2_card_glue_top DUT (.*);

    always #4 clk_logic_w = ~clk_logic_w;

    // Index 0 phi1 pos, 1 phi1 neg, 2 2M, 3 7M pos, 4 7M neg, 5 14M
    assign strobe_w = {a2_clk_o.clk_14m_posedge, a2_clk_o.clk_7m_negedge,
                       a2_clk_o.clk_7m_posedge, a2_clk_o.clk_2m_posedge,
                       a2_clk_o.phi1_negedge, a2_clk_o.phi1_posedge};

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        $display("CHECK FAILED %s expected 0x%0h got 0x%0h", name, exp, got);
        errors++;
    endtask

    task automatic check_overlay();
        if (overlay_en_o !== exp_overlay) begin
            report_mismatch("overlay_en_o", exp_overlay, overlay_en_o);
        end
    endtask

    // Shift and sum rule for one stereo sample
    function automatic audio_sample_t expected_mix(input audio_src_t s);
        audio_sample_t m;
        m.left  = 16'(s.ssp) * 16'd8 + 16'(s.mb_l) * 16'd8 + (s.speaker ? 16'h1000 : 16'h0);
        m.right = 16'(s.ssp) * 16'd8 + 16'(s.mb_r) * 16'd8 + (s.speaker ? 16'h1000 : 16'h0);
        return m;
    endfunction

    task automatic fill_tables();
        // Card order in each row is sound, sprite, serial, then bus byte and expected
        arb_tab[0] = {1'b0, 8'h00, 1'b1, 1'b0, 8'h00, 1'b1, 1'b0, 8'h00, 1'b1,
                      8'h5a, 1'b0, 8'h5a, 1'b1};
        arb_tab[1] = {1'b1, 8'h33, 1'b1, 1'b0, 8'h44, 1'b1, 1'b0, 8'h11, 1'b1,
                      8'h5a, 1'b1, 8'h33, 1'b1};
        arb_tab[2] = {1'b1, 8'h33, 1'b1, 1'b1, 8'h44, 1'b1, 1'b0, 8'h11, 1'b1,
                      8'h5a, 1'b1, 8'h44, 1'b1};
        arb_tab[3] = {1'b1, 8'h33, 1'b1, 1'b1, 8'h44, 1'b1, 1'b1, 8'h11, 1'b1,
                      8'h5a, 1'b1, 8'h11, 1'b1};
        arb_tab[4] = {1'b0, 8'h33, 1'b1, 1'b0, 8'h44, 1'b1, 1'b0, 8'h11, 1'b0,
                      8'ha5, 1'b0, 8'ha5, 1'b0};
        arb_tab[5] = {1'b1, 8'h33, 1'b0, 1'b0, 8'h44, 1'b1, 1'b1, 8'h22, 1'b1,
                      8'ha5, 1'b1, 8'h22, 1'b0};
        arb_tab[6] = {1'b0, 8'h00, 1'b1, 1'b0, 8'h66, 1'b0, 1'b0, 8'h00, 1'b1,
                      8'hff, 1'b0, 8'hff, 1'b0};
        arb_tab[7] = {1'b0, 8'h00, 1'b0, 1'b1, 8'h77, 1'b0, 1'b0, 8'h00, 1'b0,
                      8'h00, 1'b1, 8'h77, 1'b0};
        // Speaker, ssp, mb_l, mb_r, then expected left and right
        audio_tab[0] = {1'b0, 10'h000, 10'h000, 10'h000, 16'h0000, 16'h0000};
        audio_tab[1] = {1'b1, 10'h000, 10'h000, 10'h000, 16'h1000, 16'h1000};
        audio_tab[2] = {1'b1, 10'h3ff, 10'h3ff, 10'h3ff, 16'h4ff0, 16'h4ff0};
        audio_tab[3] = {1'b0, 10'h3ff, 10'h000, 10'h000, 16'h1ff8, 16'h1ff8};
        audio_tab[4] = {1'b0, 10'h000, 10'h3ff, 10'h001, 16'h1ff8, 16'h0008};
        audio_tab[5] = {1'b0, 10'h155, 10'h2aa, 10'h0f0, 16'h1ff8, 16'h1228};
        audio_tab[6] = {1'b1, 10'h001, 10'h002, 10'h200, 16'h1018, 16'h2008};
    endtask

    task automatic wait_req(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk_logic_w);
        while (sample_req_o !== level && cycles < REQ_WAIT) begin
            @(negedge clk_logic_w);
            cycles++;
        end
        if (sample_req_o !== level) begin
            $display("Audio handshake stalled, sample_req_o never went to %0b", level);
            errors++;
        end
    endtask

    task automatic drive_clk_in(input logic sel, input logic v);
        if (sel) begin
            a2_7m_i = v;
        end else begin
            a2_phi1_i = v;
        end
    endtask

    // Random bus clock with long phases and single cycle glitches inside them
    task automatic run_phase(input logic sel);
        int   base [6];
        int   highs;
        int   len;
        int   glitch_at;
        int   off;
        logic lvl;
        logic got;
        base  = strobe_cnt;
        highs = 0;
        lvl   = 1'b1;
        off   = sel ? 3 : 0;
        for (int p = 0; p < 2 * PHASE_PAIRS; p++) begin
            len       = $urandom_range(9, 3);
            glitch_at = -1;
            if (len >= 5 && $urandom_range(1, 0) == 1) begin
                glitch_at = $urandom_range(len - 3, 2);
            end
            for (int j = 0; j < len; j++) begin
                drive_clk_in(sel, (j == glitch_at) ? ~lvl : lvl);
                @(negedge clk_logic_w);
            end
            // Three cycles into a phase the recovered level has caught up
            got = sel ? a2_clk_o.clk_7m : a2_clk_o.phi1;
            if (got !== lvl) begin
                report_mismatch(sel ? "a2_clk_o.clk_7m" : "a2_clk_o.phi1", lvl, got);
            end
            if (lvl) begin
                highs++;
            end
            lvl = ~lvl;
        end
        drive_clk_in(sel, 1'b0);
        repeat (6) @(negedge clk_logic_w);
        if (strobe_cnt[off] - base[off] != highs) begin
            report_mismatch(sel ? "clk_7m_posedge count" : "phi1_posedge count",
                            highs, strobe_cnt[off] - base[off]);
        end
        if (strobe_cnt[off + 1] - base[off + 1] != highs) begin
            report_mismatch(sel ? "clk_7m_negedge count" : "phi1_negedge count",
                            highs, strobe_cnt[off + 1] - base[off + 1]);
        end
        if (strobe_cnt[off + 2] - base[off + 2] != 2 * highs) begin
            report_mismatch(sel ? "clk_14m_posedge count" : "clk_2m_posedge count",
                            2 * highs, strobe_cnt[off + 2] - base[off + 2]);
        end
    endtask

    // Edge counting and the phi0 relation on every cycle
    always @(negedge clk_logic_w) begin
        if (!reset_i) begin
            for (int k = 0; k < 6; k++) begin
                if (strobe_w[k]) begin
                    strobe_cnt[k]++;
                end
            end
        end
        if (a2_clk_o.phi0 !== ~a2_clk_o.phi1) begin
            report_mismatch("a2_clk_o.phi0", ~a2_clk_o.phi1, a2_clk_o.phi0);
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hcd885684));
        fill_tables();
        reset_i      = 1'b1;
        a2_phi1_i    = 1'b0;
        a2_7m_i      = 1'b0;
        resp_i       = {3{1'b0, 8'h00, 1'b1}};
        bus_data_i   = '0;
        src_i        = audio_tab[0].src;
        sample_ack_i = 1'b0;
        button_i     = 1'b0;
        exp_overlay  = 1'b0;

        repeat (10) begin
            @(negedge clk_logic_w);
            if (drive_o.data_out_en !== 1'b0) begin
                report_mismatch("data_out_en", 0, drive_o.data_out_en);
            end
            if (irq_n_o !== 1'b1) begin
                report_mismatch("irq_n_o", 1, irq_n_o);
            end
            if (sample_req_o !== 1'b0) begin
                report_mismatch("sample_req_o", 0, sample_req_o);
            end
            check_overlay();
            if (strobe_w !== 6'b0) begin
                report_mismatch("edge strobes", 0, strobe_w);
            end
        end
        reset_i = 1'b0;

        // Mixer already captured entry 0 as reset released
        for (int i = 0; i < AUDIO_N; i++) begin
            wait_req(1'b1);
            if (sample_o !== audio_tab[i].exp) begin
                report_mismatch("sample_o", audio_tab[i].exp, sample_o);
            end
            repeat ($urandom_range(7, 0)) @(negedge clk_logic_w);
            sample_ack_i = 1'b1;
            wait_req(1'b0);
            sample_ack_i = 1'b0;
            if (i + 1 < AUDIO_N) begin
                src_i = audio_tab[i + 1].src;
            end
        end

        // Sink stalls with ack high while the sources keep moving
        for (int r = 0; r <= BP_ROUNDS; r++) begin
            wait_req(1'b1);
            if (sample_o !== expected_mix(src_i)) begin
                report_mismatch("sample_o", expected_mix(src_i), sample_o);
            end
            sample_ack_i = 1'b1;
            wait_req(1'b0);
            if (r < BP_ROUNDS) begin
                repeat ($urandom_range(20, 4)) begin
                    rnd   = $urandom;
                    src_i = rnd[30:0];
                    @(negedge clk_logic_w);
                    if (sample_req_o !== 1'b0) begin
                        $display("sample_req_o rose while the sink still held ack high");
                        errors++;
                    end
                end
                rnd   = $urandom;
                src_i = rnd[30:0];
            end
            sample_ack_i = 1'b0;
        end

        for (int i = 0; i < ARB_N; i++) begin
            resp_i     = arb_tab[i].resp;
            bus_data_i = arb_tab[i].bus;
            @(negedge clk_logic_w);
            if (drive_o !== arb_tab[i].exp_drive) begin
                report_mismatch("drive_o", arb_tab[i].exp_drive, drive_o);
            end
            if (irq_n_o !== arb_tab[i].exp_irq_n) begin
                report_mismatch("irq_n_o", arb_tab[i].exp_irq_n, irq_n_o);
            end
        end

        run_phase(1'b0);
        run_phase(1'b1);

        for (int p = 0; p < PRESSES; p++) begin
            repeat ($urandom_range(5, 2)) begin
                button_i = 1'b1;
                repeat ($urandom_range(15, 1)) begin
                    @(negedge clk_logic_w);
                    check_overlay();
                end
                button_i = 1'b0;
                repeat ($urandom_range(15, 1)) begin
                    @(negedge clk_logic_w);
                    check_overlay();
                end
            end
            button_i = 1'b1;
            repeat (`DEBOUNCE_CYCLES + 4) @(negedge clk_logic_w);
            exp_overlay = ~exp_overlay;
            check_overlay();
            // Release must not toggle again
            button_i = 1'b0;
            repeat (`DEBOUNCE_CYCLES + 4) begin
                @(negedge clk_logic_w);
                check_overlay();
            end
        end

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+hdl
hdl/a2_bus_pkg.sv
hdl/a2_audio_pkg.sv
hdl/phase_sync.sv
hdl/card_bus_arbiter.sv
hdl/audio_mixer.sv
hdl/overlay_button.sv
hdl/a2_card_glue_top.sv
dv/a2_card_glue_tb.sv
